// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --assert --top-module tb_spi_master -f sim.f \
   && ./obj_dir/Vtb_spi_master | grep -F "*** TEST PASSED ***" \
   && echo "Simulation run: PASS" \
   || { echo "Simulation run: FAIL"; exit 1; }

// ==== sim.f ====
src/spi_pkg.sv
src/spi_regs.sv
src/spi_frame_timer.sv
src/spi_shifter.sv
src/spi_master.sv
sim/spi_master_chk.sv
sim/tb_spi_master.sv

// ==== sim/spi_master_chk.sv ====
// Frame and interrupt assertions bound into spi_master; all are off while the internal reset is high

`timescale 1ns/1ps

module spi_master_chk (
   input logic                clk,
   input logic                rst_int,
   input logic                ss,
   input spi_pkg::frame_cnt_t cnt,
   input logic                frame_done,
   input logic                irq,
   input logic                int_en,
   input logic                ready
);

   import spi_pkg::*;

   // Select low only inside the 32 data positions
   ss_window: assert property (@(posedge clk) disable iff (rst_int)
      !ss |-> (cnt >= SS_FIRST && cnt <= SS_LAST))
      else $error("ss low with frame counter at %0d", cnt);

   // Done marks the cycle where select goes back high
   done_ss: assert property (@(posedge clk) disable iff (rst_int)
      frame_done |-> $rose(ss))
      else $error("frame_done without ss rising");

   irq_rule: assert property (@(posedge clk) disable iff (rst_int)
      irq == (int_en & ready))
      else $error("irq differs from int_en and ready");

endmodule

bind spi_master spi_master_chk u_chk (
   .clk        (clk),
   .rst_int    (rst_core),
   .ss         (ss),
   .cnt        (u_timer.cnt),
   .frame_done (frame_done),
   .irq        (irq),
   .int_en     (u_regs.int_en),
   .ready      (u_regs.ready)
);

// ==== sim/tb_spi_master.sv ====
// Self-checking testbench; sclk runs at 1/8 of clk and the slave model answers LSB first

`timescale 1ns/1ps

module tb_spi_master;

   import spi_pkg::*;

   localparam int NUM_XFERS   = 20;
   localparam int TOTAL_XFERS = NUM_XFERS + 3;
   localparam int WATCHDOG_NS = TOTAL_XFERS * 64 * 160 + 50000;

   logic      clk = 1'b0;
   logic      rst_int = 1'b1;
   logic      sel = 1'b0;
   logic      read = 1'b0;
   logic      write = 1'b0;
   spi_addr_t addr = '0;
   spi_word_t wdata = '0;
   spi_word_t rdata;
   logic      irq;
   logic      sclk = 1'b0;
   logic      ss;
   logic      mosi;
   logic      miso = 1'b0;

   logic [1:0] div_cnt;
   logic [4:0] bit_idx;
   spi_word_t  slave_word = '0;
   spi_word_t  mosi_cap;
   spi_word_t  low_rises;
   spi_word_t  rises_before = '0;
   spi_word_t  rand_state = 32'h9b55_4be9;

   spi_master UUT (
      .clk(clk), .rst_int(rst_int), .sel(sel), .read(read), .write(write),
      .addr(addr), .wdata(wdata), .rdata(rdata), .irq(irq),
      .sclk(sclk), .ss(ss), .mosi(mosi), .miso(miso)
   );

   initial begin
      forever #10 clk = ~clk;
   end

   // sclk toggles every 4 clk cycles, slave acts on the rising edge
   always @(posedge clk) begin
      if (rst_int) begin
         div_cnt   <= '0;
         sclk      <= 1'b0;
         bit_idx   <= '0;
         low_rises <= '0;
         miso      <= 1'b0;
      end else begin
         div_cnt <= div_cnt + 2'd1;
         if (div_cnt == 2'd3) begin
            sclk <= ~sclk;
            if (!sclk && !ss) begin
               mosi_cap[bit_idx] <= mosi;
               miso              <= slave_word[bit_idx];
               bit_idx           <= bit_idx + 5'd1;
               low_rises         <= low_rises + 32'd1;
            end else if (!sclk) begin
               bit_idx <= '0;
            end
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the test did not finish within %0d ns", WATCHDOG_NS);
      $display("*** TEST FAILED ***");
      $fatal(1, "Watchdog expired");
   end

   function automatic spi_word_t next_random();
      spi_word_t x;
      x = rand_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rand_state = x;
      return x;
   endfunction

   task automatic check_word(input string name, input spi_word_t got, input spi_word_t exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("*** TEST FAILED ***");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("*** TEST FAILED ***");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic bus_write(input spi_addr_t a, input spi_word_t d);
      @(posedge clk);
      sel   <= 1'b1;
      write <= 1'b1;
      addr  <= a;
      wdata <= d;
      @(posedge clk);
      sel   <= 1'b0;
      write <= 1'b0;
   endtask

   // rdata is sampled mid-cycle, the DUT sees the read on the next edge
   task automatic bus_read(input spi_addr_t a, output spi_word_t d);
      @(posedge clk);
      sel  <= 1'b1;
      read <= 1'b1;
      addr <= a;
      @(negedge clk);
      d = rdata;
      @(posedge clk);
      sel  <= 1'b0;
      read <= 1'b0;
   endtask

   task automatic read_check(input spi_addr_t a, input spi_word_t exp, input string name);
      spi_word_t rd;
      bus_read(a, rd);
      check_word(name, rd, exp);
   endtask

   task automatic check_reset_state();
      read_check(ADDR_VERSION, SPI_VERSION, "version");
      read_check(ADDR_READY, 32'h1, "ready");
      read_check(ADDR_INT_EN, 32'h0, "int_en");
      read_check(ADDR_SCRATCH, 32'h0, "scratch");
      read_check(ADDR_TX, TX_RESET, "tx_word");
      @(negedge clk);
      check_bit("irq", irq, 1'b0);
      check_bit("ss", ss, 1'b1);
   endtask

   task automatic start_transfer(input spi_word_t tx, input spi_word_t slave);
      slave_word   = slave;
      rises_before = low_rises;
      bus_write(ADDR_TX, tx);
   endtask

   // Poll ready, then compare both directions of the frame
   task automatic finish_transfer(input spi_word_t tx, input spi_word_t slave,
                                  input logic irq_low);
      spi_word_t rd;
      rd = '0;
      while (rd[0] !== 1'b1) begin
         bus_read(ADDR_READY, rd);
         @(negedge clk);
         if (irq_low) begin
            check_bit("irq", irq, 1'b0);
         end
      end
      bus_read(ADDR_RX, rd);
      check_word("rx_word", rd, slave);
      check_word("mosi", mosi_cap, tx);
      check_word("ss low sclk rises", low_rises - rises_before, 32'd32);
   endtask

   initial begin : main
      spi_word_t scratch_model;
      spi_word_t tx;
      spi_word_t slave;
      spi_word_t rd;
      int        i;
      repeat (10) @(posedge clk);
      rst_int <= 1'b0;
      repeat (2) @(posedge clk);
      check_reset_state();

      for (i = 0; i < 8; i++) begin
         scratch_model = next_random();
         bus_write(ADDR_SCRATCH, scratch_model);
         read_check(ADDR_SCRATCH, scratch_model, "scratch");
      end
      bus_write(3'd7, next_random());
      read_check(3'd7, 32'h0, "unmapped");
      read_check(ADDR_SCRATCH, scratch_model, "scratch");

      // Interrupt enabled while ready is still set from reset
      bus_write(ADDR_INT_EN, 32'h1);
      @(negedge clk);
      check_bit("irq", irq, 1'b1);
      tx    = next_random();
      slave = next_random();
      start_transfer(tx, slave);
      @(negedge clk);
      check_bit("irq", irq, 1'b0);
      while (irq !== 1'b1) @(negedge clk);
      check_bit("ss", ss, 1'b1);
      finish_transfer(tx, slave, 1'b0);
      @(negedge clk);
      check_bit("irq", irq, 1'b0);
      bus_write(ADDR_INT_EN, 32'h0);
      tx    = next_random();
      slave = next_random();
      start_transfer(tx, slave);
      finish_transfer(tx, slave, 1'b1);

      for (i = 0; i < NUM_XFERS; i++) begin
         tx    = next_random();
         slave = next_random();
         start_transfer(tx, slave);
         finish_transfer(tx, slave, 1'b1);
      end

      // Soft reset brings back the power-on register values
      bus_write(ADDR_SCRATCH, next_random());
      bus_write(ADDR_INT_EN, 32'h1);
      bus_write(ADDR_SOFT_RST, 32'h1);
      check_reset_state();
      bus_read(ADDR_TX, rd);
      slave = next_random();
      start_transfer(rd, slave);
      finish_transfer(TX_RESET, slave, 1'b1);

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// ==== src/spi_frame_timer.sv ====
// Frame sequencer in the clk domain; sclk must run at least 8 times slower than clk

`timescale 1ns/1ps

module spi_frame_timer (
   input  logic clk,
   input  logic rst_int,
   input  logic sclk,
   input  logic start,
   output logic sclk_fall,
   output logic ss,
   output logic frame_idle,
   output logic frame_done
);

   import spi_pkg::*;

   logic       sclk_meta;
   logic       sclk_sync;
   logic       sclk_prev;
   logic       start_req;
   logic       launch;
   frame_cnt_t cnt;
   frame_cnt_t cnt_next;

   // Two-flop synchronizer plus edge flop
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         sclk_meta <= 1'b0;
         sclk_sync <= 1'b0;
         sclk_prev <= 1'b0;
      end else begin
         sclk_meta <= sclk;
         sclk_sync <= sclk_meta;
         sclk_prev <= sclk_sync;
      end
   end

   assign sclk_fall  = sclk_prev & ~sclk_sync;
   assign frame_idle = (cnt == FRAME_IDLE);
   assign launch     = sclk_fall & start_req & frame_idle;

   // Pending start, a new request wins over the launch clear
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         start_req <= 1'b0;
      end else begin
         start_req <= start | (start_req & ~launch);
      end
   end

   // Next count, held at idle until launched
   always_comb begin
      cnt_next = cnt;
      if (launch) begin
         cnt_next = '0;
      end else if (sclk_fall && !frame_idle) begin
         cnt_next = cnt + 6'd1;
      end
   end

   // Select and done registered from the same step as the counter
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         cnt        <= FRAME_IDLE;
         ss         <= 1'b1;
         frame_done <= 1'b0;
      end else begin
         cnt        <= cnt_next;
         ss         <= !((cnt_next >= SS_FIRST) && (cnt_next <= SS_LAST));
         frame_done <= sclk_fall & (cnt == SS_LAST);
      end
   end

endmodule

// ==== src/spi_master.sv ====
// SPI master top; single slave select, 32-bit LSB-first frames, sclk supplied from outside

`timescale 1ns/1ps

module spi_master (
   input  logic               clk,
   input  logic               rst_int,
   input  logic               sel,
   input  logic               read,
   input  logic               write,
   input  spi_pkg::spi_addr_t addr,
   input  spi_pkg::spi_word_t wdata,
   output spi_pkg::spi_word_t rdata,
   output logic               irq,
   input  logic               sclk,
   output logic               ss,
   output logic               mosi,
   input  logic               miso
);

   import spi_pkg::*;

   logic      rst_core;
   logic      soft_rst;
   logic      start;
   logic      sclk_fall;
   logic      frame_idle;
   logic      frame_done;
   spi_word_t tx_word;
   spi_word_t rx_word;

   // Internal reset covers both the pin and the soft reset pulse
   assign rst_core = rst_int | soft_rst;

   spi_regs u_regs (
      .clk        (clk),
      .rst_int    (rst_core),
      .sel        (sel),
      .read       (read),
      .write      (write),
      .addr       (addr),
      .wdata      (wdata),
      .rdata      (rdata),
      .irq        (irq),
      .frame_idle (frame_idle),
      .frame_done (frame_done),
      .rx_word    (rx_word),
      .tx_word    (tx_word),
      .start      (start),
      .soft_rst   (soft_rst)
   );

   spi_frame_timer u_timer (
      .clk        (clk),
      .rst_int    (rst_core),
      .sclk       (sclk),
      .start      (start),
      .sclk_fall  (sclk_fall),
      .ss         (ss),
      .frame_idle (frame_idle),
      .frame_done (frame_done)
   );

   spi_shifter u_shifter (
      .clk        (clk),
      .rst_int    (rst_core),
      .sclk_fall  (sclk_fall),
      .ss         (ss),
      .tx_word    (tx_word),
      .miso       (miso),
      .mosi       (mosi),
      .rx_word    (rx_word)
   );

endmodule

// ==== src/spi_pkg.sv ====
// Shared widths, register map and frame positions; the frame length is fixed at 64 sclk falls

package spi_pkg;

   // Bus and frame widths
   localparam int SPI_DATA_W = 32;
   localparam int SPI_ADDR_W = 3;

   typedef logic [SPI_DATA_W-1:0] spi_word_t;
   typedef logic [SPI_ADDR_W-1:0] spi_addr_t;
   typedef logic [5:0]            frame_cnt_t;

   // Frame counter positions
   localparam frame_cnt_t FRAME_IDLE = 6'd63;
   localparam frame_cnt_t SS_FIRST   = 6'd16;
   localparam frame_cnt_t SS_LAST    = 6'd47;

   // Register map, address 7 is unmapped
   localparam spi_addr_t ADDR_INT_EN   = 3'd0;
   localparam spi_addr_t ADDR_READY    = 3'd1;
   localparam spi_addr_t ADDR_TX       = 3'd2;
   localparam spi_addr_t ADDR_RX       = 3'd3;
   localparam spi_addr_t ADDR_VERSION  = 3'd4;
   localparam spi_addr_t ADDR_SOFT_RST = 3'd5;
   localparam spi_addr_t ADDR_SCRATCH  = 3'd6;

   // Fixed read values
   localparam spi_word_t SPI_VERSION = 32'h0001_0200;
   localparam spi_word_t TX_RESET    = 32'hF0F0_F0F0;

endpackage

// ==== src/spi_regs.sv ====
// Host register block; rdata is combinational from addr, RX and ready read the datapath live

`timescale 1ns/1ps

module spi_regs (
   input  logic                clk,
   input  logic                rst_int,
   input  logic                sel,
   input  logic                read,
   input  logic                write,
   input  spi_pkg::spi_addr_t  addr,
   input  spi_pkg::spi_word_t  wdata,
   output spi_pkg::spi_word_t  rdata,
   output logic                irq,
   input  logic                frame_idle,
   input  logic                frame_done,
   input  spi_pkg::spi_word_t  rx_word,
   output spi_pkg::spi_word_t  tx_word,
   output logic                start,
   output logic                soft_rst
);

   import spi_pkg::*;

   logic      wr_en;
   logic      rd_en;
   logic      int_en_wr;
   logic      scratch_wr;
   logic      soft_rst_wr;
   logic      rx_rd;
   logic      int_en;
   logic      ready;
   spi_word_t tx_reg;
   spi_word_t scratch;

   assign wr_en = sel & write;
   assign rd_en = sel & read;

   // Address decode for the strobes
   assign int_en_wr   = wr_en & (addr == ADDR_INT_EN);
   assign start       = wr_en & (addr == ADDR_TX);
   assign soft_rst_wr = wr_en & (addr == ADDR_SOFT_RST);
   assign scratch_wr  = wr_en & (addr == ADDR_SCRATCH);
   assign rx_rd       = rd_en & (addr == ADDR_RX);

   // Read mux
   always_comb begin
      rdata = '0;
      case (addr)
         ADDR_INT_EN:   rdata = {{(SPI_DATA_W-1){1'b0}}, int_en};
         ADDR_READY:    rdata = {{(SPI_DATA_W-1){1'b0}}, ready & frame_idle};
         ADDR_TX:       rdata = tx_reg;
         ADDR_RX:       rdata = rx_word;
         ADDR_VERSION:  rdata = SPI_VERSION;
         ADDR_SCRATCH:  rdata = scratch;
         default:       rdata = '0;
      endcase
   end

   // Word to send, held until the next TX write
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         tx_reg <= TX_RESET;
      end else if (start) begin
         tx_reg <= wdata;
      end
   end

   assign tx_word = tx_reg;

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         int_en <= 1'b0;
      end else if (int_en_wr) begin
         int_en <= wdata[0];
      end
   end

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         scratch <= '0;
      end else if (scratch_wr) begin
         scratch <= wdata;
      end
   end

   // Ready drops on TX write or RX read, clear beats set
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         ready <= 1'b1;
      end else if (start | rx_rd) begin
         ready <= 1'b0;
      end else if (frame_done) begin
         ready <= 1'b1;
      end
   end

   // Soft reset pulse, one full clk period wide
   always_ff @(posedge clk) begin
      soft_rst <= soft_rst_wr;
   end

   assign irq = int_en & ready;

endmodule

// ==== src/spi_shifter.sv ====
// Serial shift registers, LSB first; miso is sampled 3 clk cycles after the sclk fall

`timescale 1ns/1ps

module spi_shifter (
   input  logic               clk,
   input  logic               rst_int,
   input  logic               sclk_fall,
   input  logic               ss,
   input  spi_pkg::spi_word_t tx_word,
   input  logic               miso,
   output logic               mosi,
   output spi_pkg::spi_word_t rx_word
);

   import spi_pkg::*;

   spi_word_t tx_shift;
   spi_word_t rx_shift;

   // Reload while deselected, shift out while selected
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         tx_shift <= TX_RESET;
      end else if (sclk_fall) begin
         if (ss) begin
            tx_shift <= tx_word;
         end else begin
            tx_shift <= tx_shift >> 1;
         end
      end
   end

   assign mosi = tx_shift[0];

   // New bit enters at the top, first bit ends at bit 0
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         rx_shift <= '0;
      end else if (sclk_fall && !ss) begin
         rx_shift <= {miso, rx_shift[SPI_DATA_W-1:1]};
      end
   end

   assign rx_word = rx_shift;

endmodule
